// File: bdDecoder.f
verilog/bdDecodePkg.sv
verilog/bdRouteDecoder.sv
verilog/bdPartFsm.sv
verilog/bdPartTimer.sv
verilog/bdWordAssembler.sv
verilog/bdDecoder.sv
verif/tbClock.sv
verif/bdDecoderChecker.sv
verif/bdDecoder_asserts.sv
verif/bdDecoderTb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the bdDecoder testbench with Verilator.
# Exits non-zero when the build, the run or the log check fails.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert \
  --top-module bdDecoderTb \
  -f bdDecoder.f \
  -o bdDecoderSim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/bdDecoderSim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Errors found" "$LOG"; then
  echo "FAIL"
  exit 1
fi

echo "PASS"
exit 0

// File: verif/bdDecoderChecker.sv
`timescale 1ns/1ps

module bdDecoderChecker (
  input logic                clk,
  input logic                rstN,
  input logic                bdInValid,
  input logic                bdInAck,
  input bdDecodePkg::bdWordT decOut,
  input logic                decOutValid,
  input logic                decOutAck,
  input logic                orphanDrop
);

  ////////////////////
  // expected queue
  ////////////////////

  // one entry per test, either a word or a drop pulse
  string               expName[$];
  bdDecodePkg::bdWordT expWord[$];
  logic                expDrop[$];
  int                  passCount = 0;
  int                  errCount = 0;

  task automatic expectWord(input string name, input bdDecodePkg::bdWordT w);
    expName.push_back(name);
    expWord.push_back(w);
    expDrop.push_back(1'b0);
  endtask

  task automatic expectDrop(input string name);
    expName.push_back(name);
    expWord.push_back('0);
    expDrop.push_back(1'b1);
  endtask

  task automatic popHead();
    void'(expName.pop_front());
    void'(expWord.pop_front());
    void'(expDrop.pop_front());
  endtask

  function automatic int pending();
    return expName.size();
  endfunction

  ////////////////////
  // compare
  ////////////////////

  task automatic checkWord();
    if (expName.size() == 0) begin
      $display("output word %h appeared with no test waiting for it", decOut);
      errCount++;
    end else begin
      if (expDrop[0]) begin
        $display("test %s waited for orphanDrop but got word %h", expName[0], decOut);
        errCount++;
      end else if (decOut !== expWord[0]) begin
        $display("error %s expected %h actual %h", expName[0], expWord[0], decOut);
        errCount++;
      end else begin
        $display("pass %s", expName[0]);
        passCount++;
      end
      popHead();
    end
  endtask

  task automatic checkDrop();
    if (expName.size() > 0 && expDrop[0]) begin
      $display("pass %s", expName[0]);
      passCount++;
      popHead();
    end else begin
      $display("orphanDrop pulsed although no first half was left waiting");
      errCount++;
    end
  endtask

  // anything still queued never showed up
  task automatic reportMissing();
    while (expName.size() > 0) begin
      if (expDrop[0]) begin
        $display("test %s never saw its orphanDrop pulse", expName[0]);
      end else begin
        $display("test %s never received its output word", expName[0]);
      end
      errCount++;
      popHead();
    end
  endtask

  // sampled on the rising edge, inputs move on the falling one
  always @(posedge clk) begin
    if (rstN) begin
      if (decOutValid && decOutAck) begin
        checkWord();
      end
      if (orphanDrop) begin
        checkDrop();
      end
      // stalled output must hold the input back
      if (bdInValid && bdInAck && decOutValid && !decOutAck) begin
        $display("input word accepted while the output was stalled");
        errCount++;
      end
    end
  end

endmodule

// File: verif/bdDecoderTb.sv
`timescale 1ns/1ps

module bdDecoderTb;

  // row kinds
  localparam int Single = 0;
  localparam int FirstHalf = 1;
  localparam int SecondHalf = 2;
  localparam int Orphan = 3;
  localparam logic [31:0] LfsrTaps = 32'h8020_0003;

  logic                clk;
  logic                rstN;
  logic [33:0]         bdIn;
  logic                bdInValid;
  logic                bdInAck;
  bdDecodePkg::bdWordT decOut;
  logic                decOutValid;
  logic                decOutAck;
  logic                orphanDrop;

  // routes right-aligned, by leaf index
  int routeVal [13] = '{'b100100000000000, 'b100100000000001, 'b10010000000001,
                        'b100100000001100, 'b100100000001101, 'b10010000000101,
                        'b10000, 'b10001, 'b101, 'b10010000000100,
                        'b10010000000100, 'b01, 'b00};
  int routeLen [13] = '{15, 15, 14, 15, 15, 14, 5, 5, 3, 14, 14, 2, 2};

  ////////////////////
  // stimulus table
  ////////////////////

  string       rowName[$];
  int          rowLeaf[$];
  logic [33:0] rowRaw[$];
  int          rowGap[$];
  int          rowAckHold[$];
  int          rowKind[$];
  logic [3:0]  rowCode[$];

  logic [31:0] lfsr = 32'hee0b_9bfa;
  logic [18:0] firstHalf = '0;
  int          cycleCount = 0;
  int          cycleLimit = 0;

  tbClock i_clock (
    .clk  (clk),
    .rstN (rstN)
  );

  bdDecoder #(
    .TimeoutCycles (16)
  ) i_dut (
    .clk         (clk),
    .rstN        (rstN),
    .bdIn        (bdIn),
    .bdInValid   (bdInValid),
    .bdInAck     (bdInAck),
    .decOut      (decOut),
    .decOutValid (decOutValid),
    .decOutAck   (decOutAck),
    .orphanDrop  (orphanDrop)
  );

  bdDecoderChecker i_checker (
    .clk         (clk),
    .rstN        (rstN),
    .bdInValid   (bdInValid),
    .bdInAck     (bdInAck),
    .decOut      (decOut),
    .decOutValid (decOutValid),
    .decOutAck   (decOutAck),
    .orphanDrop  (orphanDrop)
  );

  // galois shift right
  function automatic logic [31:0] lfsrStep(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ LfsrTaps;
    end
    return s >> 1;
  endfunction

  // one lfsr step per payload bit
  task automatic drawBits(input int n, output logic [33:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v[i] = lfsr[0];
      lfsr = lfsrStep(lfsr);
    end
  endtask

  task automatic addRow(input string name, input int leaf, input logic [33:0] raw,
                        input int gap, input int ackHold, input int kind,
                        input logic [3:0] code);
    rowName.push_back(name);
    rowLeaf.push_back(leaf);
    rowRaw.push_back(raw);
    rowGap.push_back(gap);
    rowAckHold.push_back(ackHold);
    rowKind.push_back(kind);
    rowCode.push_back(code);
  endtask

  ////////////////////
  // drive one row
  ////////////////////

  task automatic sendRow(input int r);
    logic [33:0]         pay;
    logic [33:0]         word;
    bdDecodePkg::bdWordT exp;
    int                  held;
    logic                accepted;
    bdInValid = 1'b0;
    repeat (rowGap[r]) @(negedge clk);
    if (rowLeaf[r] < 0) begin
      // no route, low 32 bits pass as they are
      word = rowRaw[r];
      pay = 34'(word[31:0]);
    end else begin
      drawBits(34 - routeLen[rowLeaf[r]], pay);
      word = (34'(routeVal[rowLeaf[r]]) << (34 - routeLen[rowLeaf[r]])) | pay;
    end
    exp.leafCode = bdDecodePkg::leafE'(rowCode[r]);
    exp.payload = 38'(pay);
    case (rowKind[r])
      FirstHalf: firstHalf = pay[18:0];
      Orphan: begin
        firstHalf = pay[18:0];
        i_checker.expectDrop(rowName[r]);
      end
      SecondHalf: begin
        // first half low, second half high
        exp.payload = {pay[18:0], firstHalf};
        i_checker.expectWord(rowName[r], exp);
      end
      default: i_checker.expectWord(rowName[r], exp);
    endcase
    bdIn = word;
    bdInValid = 1'b1;
    decOutAck = (rowAckHold[r] > 0) ? 1'b0 : 1'b1;
    held = 0;
    accepted = 1'b0;
    // hold the word until the DUT takes it
    while (!accepted) begin
      @(posedge clk);
      accepted = bdInAck;
      @(negedge clk);
      held++;
      if (held >= rowAckHold[r]) begin
        decOutAck = 1'b1;
      end
    end
    bdInValid = 1'b0;
  endtask

  initial begin : mainSeq
    bdIn = '0;
    bdInValid = 1'b0;
    decOutAck = 1'b1;
    // name, leaf, raw word, gap, ack hold, kind, expected code
    addRow("dump mm", 1, '0, 0, 0, Single, 4'd1);
    addRow("dump pat", 2, '0, 0, 0, Single, 4'd2);
    addRow("dump post fifo0", 3, '0, 1, 0, Single, 4'd3);
    addRow("dump post fifo1", 4, '0, 0, 0, Single, 4'd4);
    addRow("dump pre fifo", 5, '0, 0, 0, Single, 4'd5);
    addRow("dump tat0", 6, '0, 2, 0, Single, 4'd6);
    addRow("dump tat1", 7, '0, 0, 0, Single, 4'd7);
    addRow("nrni", 8, '0, 0, 0, Single, 4'd8);
    addRow("ro acc", 11, '0, 0, 0, Single, 4'd11);
    addRow("ro tat", 12, '0, 0, 0, Single, 4'd12);
    addRow("ovflw route", 9, '0, 0, 0, Single, 4'd9);
    addRow("ovflw1 route", 10, '0, 0, 0, Single, 4'd9);
    addRow("invalid top bits", -1, 34'h3_dead_beef, 0, 0, Single, 4'd13);
    addRow("invalid dump prefix", -1, 34'h2_4070_1234, 1, 0, Single, 4'd13);
    addRow("am pair", 0, '0, 0, 0, FirstHalf, 4'd0);
    addRow("am pair", 0, '0, 0, 0, SecondHalf, 4'd0);
    addRow("interleave am", 0, '0, 1, 0, FirstHalf, 4'd0);
    addRow("interleave nrni", 8, '0, 0, 0, Single, 4'd8);
    addRow("interleave ro tat", 12, '0, 2, 0, Single, 4'd12);
    addRow("interleave am", 0, '0, 0, 0, SecondHalf, 4'd0);
    addRow("orphan half", 0, '0, 0, 0, Orphan, 4'd0);
    addRow("pair after drop", 0, '0, 20, 0, FirstHalf, 4'd0);
    addRow("pair after drop", 0, '0, 0, 0, SecondHalf, 4'd0);
    addRow("stalled dump mm", 1, '0, 0, 5, Single, 4'd1);
    addRow("stalled am pair", 0, '0, 0, 0, FirstHalf, 4'd0);
    addRow("stalled am pair", 0, '0, 0, 6, SecondHalf, 4'd0);
    addRow("stalled ro acc", 11, '0, 0, 3, Single, 4'd11);
    addRow("after stall tat1", 7, '0, 2, 0, Single, 4'd7);
    cycleLimit = 100;
    foreach (rowGap[r]) begin
      cycleLimit += rowGap[r] + 4;
    end
    wait (rstN === 1'b1);
    @(negedge clk);
    for (int r = 0; r < rowName.size(); r++) begin
      sendRow(r);
    end
    // let the last words drain
    for (int w = 0; w < 30 && i_checker.pending() > 0; w++) begin
      @(negedge clk);
    end
    i_checker.reportMissing();
    $display("tests passed %0d failed %0d", i_checker.passCount, i_checker.errCount);
    if (i_checker.errCount == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  // run limit from the table length
  initial begin : watchdog
    @(posedge clk);
    while (cycleCount < cycleLimit) begin
      @(posedge clk);
      cycleCount++;
    end
    $display("run stopped at cycle %0d before all tests finished", cycleCount);
    $display("Errors found");
    $finish;
  end

endmodule

// File: verif/bdDecoder_asserts.sv
`timescale 1ns/1ps

module bdDecoderAsserts (
  input logic clk,
  input logic rstN,
  input logic bdInValid,
  input logic bdInAck,
  input logic capture,
  input logic emitWhole,
  input logic orphanDrop
);

  // no ack for a word that is not there
  ackNeedsValid: assert property (@(posedge clk) disable iff (!rstN)
    bdInAck |-> bdInValid)
    else $error("bdInAck high while bdInValid is low");

  // drop flag is a pulse
  dropIsPulse: assert property (@(posedge clk) disable iff (!rstN)
    orphanDrop |=> !orphanDrop)
    else $error("orphanDrop held high for more than one cycle");

  // a half is either stored or emitted
  captureOrEmit: assert property (@(posedge clk) disable iff (!rstN)
    !(capture && emitWhole))
    else $error("capture and emitWhole high in the same cycle");

endmodule

bind bdPartFsm bdDecoderAsserts i_asserts (
  .clk        (clk),
  .rstN       (rstN),
  .bdInValid  (bdInValid),
  .bdInAck    (bdInAck),
  .capture    (capture),
  .emitWhole  (emitWhole),
  .orphanDrop (orphanDrop)
);

// File: verif/tbClock.sv
`timescale 1ns/1ps

module tbClock (
  output logic clk,
  output logic rstN
);

  // 4 ns period
  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // low for 3 cycles, released on a falling edge
  initial begin
    rstN = 1'b0;
    repeat (3) @(negedge clk);
    rstN = 1'b1;
  end

endmodule

// File: verilog/bdDecodePkg.sv
package bdDecodePkg;

  ////////////////////
  // widths
  ////////////////////

  // raw word out of the BD horn
  localparam int BdWordWidth = 34;
  // one half of a two-part DUMP_AM word
  localparam int PartWidth = 19;
  // assembled DUMP_AM is the widest payload
  localparam int PayloadWidth = 2 * PartWidth;
  // anything single-part fits in here
  localparam int SinglePayloadWidth = 32;
  localparam int LeafCodeWidth = 4;
  localparam int NumLeaves = 13;

  ////////////////////
  // leaf codes
  ////////////////////

  // enum value is the output leaf code
  typedef enum logic [LeafCodeWidth-1:0] {
    DUMP_AM         = 4'd0,
    DUMP_MM         = 4'd1,
    DUMP_PAT        = 4'd2,
    DUMP_POST_FIFO0 = 4'd3,
    DUMP_POST_FIFO1 = 4'd4,
    DUMP_PRE_FIFO   = 4'd5,
    DUMP_TAT0       = 4'd6,
    DUMP_TAT1       = 4'd7,
    NRNI            = 4'd8,
    OVFLW0          = 4'd9,
    OVFLW1          = 4'd10,
    RO_ACC          = 4'd11,
    RO_TAT          = 4'd12,
    INVALID         = 4'd13
  } leafE;

  ////////////////////
  // route tables
  ////////////////////

  // routes left-aligned in the word, indexed by leaf code
  // overflow routes are only partly known, so both leaves share one
  localparam logic [0:NumLeaves-1][BdWordWidth-1:0] routeTable = '{
    BdWordWidth'(15'b100100000000000) << (BdWordWidth - 15),
    BdWordWidth'(15'b100100000000001) << (BdWordWidth - 15),
    BdWordWidth'(14'b10010000000001) << (BdWordWidth - 14),
    BdWordWidth'(15'b100100000001100) << (BdWordWidth - 15),
    BdWordWidth'(15'b100100000001101) << (BdWordWidth - 15),
    BdWordWidth'(14'b10010000000101) << (BdWordWidth - 14),
    BdWordWidth'(5'b10000) << (BdWordWidth - 5),
    BdWordWidth'(5'b10001) << (BdWordWidth - 5),
    BdWordWidth'(3'b101) << (BdWordWidth - 3),
    BdWordWidth'(14'b10010000000100) << (BdWordWidth - 14),
    BdWordWidth'(14'b10010000000100) << (BdWordWidth - 14),
    BdWordWidth'(2'b01) << (BdWordWidth - 2),
    BdWordWidth'(2'b00) << (BdWordWidth - 2)
  };

  // route length in bits, same order
  localparam logic [0:NumLeaves-1][5:0] routeLenTable = '{
    6'd15, 6'd15, 6'd14, 6'd15, 6'd15, 6'd14, 6'd5,
    6'd5, 6'd3, 6'd14, 6'd14, 6'd2, 6'd2
  };

  // decoded word, code on top
  typedef struct packed {
    leafE leafCode;
    logic [PayloadWidth-1:0] payload;
  } bdWordT;

endpackage

// File: verilog/bdDecoder.sv
`timescale 1ns/1ps

module bdDecoder #(
  parameter int TimeoutCycles = 16
) (
  input  logic                clk,
  input  logic                rstN,
  input  logic [33:0]         bdIn,
  input  logic                bdInValid,
  output logic                bdInAck,
  output bdDecodePkg::bdWordT decOut,
  output logic                decOutValid,
  input  logic                decOutAck,
  output logic                orphanDrop
);

  bdDecodePkg::bdWordT rawWord;
  logic                capture;
  logic                emitWhole;
  logic                timerStart;
  logic                timerStop;
  logic                expired;

  ////////////////////
  // route decode
  ////////////////////

  bdRouteDecoder i_routeDecoder (
    .bdIn    (bdIn),
    .rawWord (rawWord)
  );

  ////////////////////
  // two-part control
  ////////////////////

  bdPartFsm i_partFsm (
    .clk         (clk),
    .rstN        (rstN),
    .leafCode    (rawWord.leafCode),
    .bdInValid   (bdInValid),
    .decOutAck   (decOutAck),
    .expired     (expired),
    .bdInAck     (bdInAck),
    .decOutValid (decOutValid),
    .capture     (capture),
    .emitWhole   (emitWhole),
    .timerStart  (timerStart),
    .timerStop   (timerStop),
    .orphanDrop  (orphanDrop)
  );

  // orphan timeout
  bdPartTimer #(
    .TimeoutCycles (TimeoutCycles)
  ) i_partTimer (
    .clk        (clk),
    .rstN       (rstN),
    .timerStart (timerStart),
    .timerStop  (timerStop),
    .expired    (expired)
  );

  // half store and output mux
  bdWordAssembler i_wordAssembler (
    .clk       (clk),
    .rstN      (rstN),
    .rawWord   (rawWord),
    .capture   (capture),
    .emitWhole (emitWhole),
    .decOut    (decOut)
  );

endmodule

// File: verilog/bdPartFsm.sv
`timescale 1ns/1ps

module bdPartFsm (
  input  logic              clk,
  input  logic              rstN,
  input  bdDecodePkg::leafE leafCode,
  input  logic              bdInValid,
  input  logic              decOutAck,
  input  logic              expired,
  output logic              bdInAck,
  output logic              decOutValid,
  output logic              capture,
  output logic              emitWhole,
  output logic              timerStart,
  output logic              timerStop,
  output logic              orphanDrop
);

  typedef enum logic {
    Idle,
    Waiting
  } stateE;

  stateE state;
  stateE stateNext;
  logic  isAm;

  // only place the AM leaf is recognized
  assign isAm = (leafCode == bdDecodePkg::DUMP_AM);

  ////////////////////
  // next state, handshake
  ////////////////////

  always_comb begin
    // default is passthrough, zero latency
    stateNext   = state;
    decOutValid = bdInValid;
    bdInAck     = bdInValid & decOutAck;
    capture     = 1'b0;
    emitWhole   = 1'b0;
    timerStart  = 1'b0;
    timerStop   = 1'b0;
    if (state == Idle) begin
      if (bdInValid && isAm) begin
        // first half goes into the assembler, nothing out
        decOutValid = 1'b0;
        bdInAck     = 1'b1;
        capture     = 1'b1;
        timerStart  = 1'b1;
        stateNext   = Waiting;
      end
    end else if (expired) begin
      // first half orphaned, hold off any AM half this cycle
      stateNext = Idle;
      if (isAm) begin
        decOutValid = 1'b0;
        bdInAck     = 1'b0;
      end
    end else if (bdInValid && isAm) begin
      // second half, emit the pair
      emitWhole = 1'b1;
      if (decOutAck) begin
        timerStop = 1'b1;
        stateNext = Idle;
      end
    end
  end

  ////////////////////
  // registers
  ////////////////////

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      state      <= Idle;
      orphanDrop <= 1'b0;
    end else begin
      state      <= stateNext;
      // single-cycle drop flag
      orphanDrop <= (state == Waiting) && expired;
    end
  end

endmodule

// File: verilog/bdPartTimer.sv
`timescale 1ns/1ps

module bdPartTimer #(
  parameter int TimeoutCycles = 16
) (
  input  logic clk,
  input  logic rstN,
  input  logic timerStart,
  input  logic timerStop,
  output logic expired
);

  localparam int CountWidth = $clog2(TimeoutCycles + 1);

  logic                  armed;
  logic [CountWidth-1:0] count;

  // count holds the edges seen since the first half, start edge included
  assign expired = armed && (count == CountWidth'(TimeoutCycles));

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      armed <= 1'b0;
      count <= '0;
    end else if (timerStart) begin
      armed <= 1'b1;
      count <= CountWidth'(1);
    end else if (timerStop || expired) begin
      // second half taken or wait over
      armed <= 1'b0;
      count <= '0;
    end else if (armed) begin
      count <= count + 1'b1;
    end
  end

endmodule

// File: verilog/bdRouteDecoder.sv
`timescale 1ns/1ps

module bdRouteDecoder (
  input  logic [33:0]          bdIn,
  output bdDecodePkg::bdWordT  rawWord
);

  ////////////////////
  // parallel match
  ////////////////////

  // one match bit per leaf, bit index is the leaf code
  logic [bdDecodePkg::NumLeaves-1:0] match;
  // payload mask per leaf, everything below the route
  logic [bdDecodePkg::NumLeaves-1:0][bdDecodePkg::BdWordWidth-1:0] leafPayMask;

  for (genvar i = 0; i < bdDecodePkg::NumLeaves; i++) begin : gLeaf
    localparam logic [bdDecodePkg::BdWordWidth-1:0] PayMask =
      {bdDecodePkg::BdWordWidth{1'b1}} >> bdDecodePkg::routeLenTable[i];
    assign leafPayMask[i] = PayMask;
    // route bits only, compared against the table
    assign match[i] = ((bdIn & ~PayMask) == bdDecodePkg::routeTable[i]);
  end

  ////////////////////
  // one-hot to code
  ////////////////////

  bdDecodePkg::leafE leaf;
  logic [bdDecodePkg::BdWordWidth-1:0] payMask;
  logic [bdDecodePkg::BdWordWidth-1:0] maskedWord;

  always_comb begin
    case (match)
      13'b0_0000_0000_0001: leaf = bdDecodePkg::DUMP_AM;
      13'b0_0000_0000_0010: leaf = bdDecodePkg::DUMP_MM;
      13'b0_0000_0000_0100: leaf = bdDecodePkg::DUMP_PAT;
      13'b0_0000_0000_1000: leaf = bdDecodePkg::DUMP_POST_FIFO0;
      13'b0_0000_0001_0000: leaf = bdDecodePkg::DUMP_POST_FIFO1;
      13'b0_0000_0010_0000: leaf = bdDecodePkg::DUMP_PRE_FIFO;
      13'b0_0000_0100_0000: leaf = bdDecodePkg::DUMP_TAT0;
      13'b0_0000_1000_0000: leaf = bdDecodePkg::DUMP_TAT1;
      13'b0_0001_0000_0000: leaf = bdDecodePkg::NRNI;
      13'b0_0010_0000_0000: leaf = bdDecodePkg::OVFLW0;
      13'b0_0100_0000_0000: leaf = bdDecodePkg::OVFLW1;
      // identical overflow routes always hit together
      13'b0_0110_0000_0000: leaf = bdDecodePkg::OVFLW0;
      13'b0_1000_0000_0000: leaf = bdDecodePkg::RO_ACC;
      13'b1_0000_0000_0000: leaf = bdDecodePkg::RO_TAT;
      default:              leaf = bdDecodePkg::INVALID;
    endcase
  end

  // invalid keeps the whole word
  always_comb begin
    payMask = {bdDecodePkg::BdWordWidth{1'b1}};
    for (int i = 0; i < bdDecodePkg::NumLeaves; i++) begin
      if (leaf == bdDecodePkg::leafE'(i)) begin
        payMask = leafPayMask[i];
      end
    end
  end

  assign maskedWord = bdIn & payMask;

  // truncate to the single-part limit, zero-extend
  assign rawWord.leafCode = leaf;
  assign rawWord.payload = bdDecodePkg::PayloadWidth'(
    maskedWord[bdDecodePkg::SinglePayloadWidth-1:0]);

endmodule

// File: verilog/bdWordAssembler.sv
`timescale 1ns/1ps

module bdWordAssembler (
  input  logic                clk,
  input  logic                rstN,
  input  bdDecodePkg::bdWordT rawWord,
  input  logic                capture,
  input  logic                emitWhole,
  output bdDecodePkg::bdWordT decOut
);

  ////////////////////
  // first half store
  ////////////////////

  logic [bdDecodePkg::PartWidth-1:0] halfQ;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      halfQ <= '0;
    end else if (capture) begin
      halfQ <= rawWord.payload[bdDecodePkg::PartWidth-1:0];
    end
  end

  ////////////////////
  // output select
  ////////////////////

  always_comb begin
    if (emitWhole) begin
      // first half low, second half high
      decOut.leafCode = bdDecodePkg::DUMP_AM;
      decOut.payload  = {rawWord.payload[bdDecodePkg::PartWidth-1:0], halfQ};
    end else begin
      // every other leaf untouched
      decOut = rawWord;
    end
  end

endmodule
